// File: rtl/pet_regs_pkg.sv
/* PET control register definitions */
package pet_regs_pkg;

    // Bus and register widths
    localparam int DATA_WIDTH     = 8;
    localparam int REG_ADDR_WIDTH = 4;

    // Single 8-bit lane
    typedef logic [DATA_WIDTH-1:0]     data_t;
    // 16 register locations
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Register map
    localparam reg_addr_t REG_STATUS = 4'd0;
    localparam reg_addr_t REG_CPU    = 4'd1;
    localparam reg_addr_t REG_VIDEO  = 4'd2;

    // Status register bits, read-only
    localparam int REG_STATUS_GRAPHICS_BIT = 0;
    localparam int REG_STATUS_CRT_BIT      = 1;
    localparam int REG_STATUS_KEYBOARD_BIT = 2;

    // CPU control register bits
    localparam int REG_CPU_READY_BIT = 0;
    localparam int REG_CPU_RESET_BIT = 1;
    localparam int REG_CPU_NMI_BIT   = 2;

    // Video control register bits
    localparam int REG_VIDEO_COL_80_BIT    = 0;
    localparam int REG_VIDEO_RAM_MASK_LSB  = 1;
    localparam int REG_VIDEO_RAM_MASK_MSB  = 2;

    // CPU held in reset, not ready, no NMI
    localparam data_t CPU_RESET_VALUE   = 8'b0000_0010;
    // 40 columns, no RAM mask
    localparam data_t VIDEO_RESET_VALUE = 8'b0000_0000;

    // One register access, valid for a single cycle
    typedef struct packed {
        logic      valid;
        logic      write;
        reg_addr_t addr;
        data_t     wdata;
    } reg_req_t;

    // Status inputs, graphics in the LSB
    typedef struct packed {
        logic keyboard;
        logic crt;
        logic graphics;
    } status_t;

    // CPU control lines, ready in the LSB
    typedef struct packed {
        logic nmi;
        logic reset;
        logic ready;
    } cpu_ctl_t;

    // Video control lines
    typedef struct packed {
        logic [1:0] ram_mask;
        logic       col_80_mode;
    } video_ctl_t;

endpackage

// File: rtl/reg_bus_slave.sv
/* Pipelined Wishbone register slave */
`timescale 1ns/1ps

module reg_bus_slave
    import pet_regs_pkg::*;
(
    input  logic      clock_i,
    input  logic      reset_n_i,

    // Wishbone pipelined slave port
    input  logic      wb_cycle_i,
    input  logic      wb_strobe_i,
    input  logic      wb_we_i,
    input  logic      wb_sel_i,
    input  reg_addr_t wb_addr_i,
    input  data_t     wb_data_i,
    output data_t     wb_data_o,
    output logic      wb_ack_o,
    output logic      wb_stall_o,

    // Register file side
    output reg_req_t  req_o,
    input  data_t     rdata_i
);

    // Request accepted this edge
    logic  accept;
    // Read access accepted this edge
    logic  read_accept;
    // Registered ack, one cycle after accept
    logic  ack_q;
    // Registered read data, zero outside read acks
    data_t data_q;

    // Cycle and strobe together form a request
    assign accept      = wb_cycle_i && wb_strobe_i;
    assign read_accept = accept && !wb_we_i;

    // Register file sees the request in the accepting cycle
    always_comb begin
        req_o.valid = accept;
        // Byte lane off means no write at all
        req_o.write = accept && wb_we_i && wb_sel_i;
        req_o.addr  = wb_addr_i;
        req_o.wdata = wb_data_i;
    end

    // Ack and read data return one cycle later
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            ack_q  <= 1'b0;
            data_q <= '0;
        end else begin
            // One ack per accepted strobe, in order
            ack_q <= accept;

            // Capture the mux output for reads only
            if (read_accept) begin
                data_q <= rdata_i;
            end else begin
                data_q <= '0;
            end
        end
    end

    assign wb_ack_o  = ack_q;
    assign wb_data_o = data_q;

    // Single-cycle access, the bus never waits
    assign wb_stall_o = 1'b0;

endmodule

// File: rtl/register_file.sv
/* PET control register file */
`timescale 1ns/1ps

module register_file
    import pet_regs_pkg::*;
(
    input  logic       clock_i,
    input  logic       reset_n_i,

    // Access from the bus slave
    input  reg_req_t   req_i,
    output data_t      rdata_o,

    // Asynchronous status inputs
    input  status_t    status_i,

    // Control outputs
    output cpu_ctl_t   cpu_o,
    output video_ctl_t video_o
);

    // Flip-flops between the pins and the status byte
    localparam int SYNC_STAGES = 2;

    // Synchronizer chain, stage 0 samples the pins
    status_t [SYNC_STAGES-1:0] sync_q;
    // Synchronized status, last stage
    status_t                   status_sync;
    // Status byte as seen by reads
    data_t                     status_byte;

    // Writable registers, full bytes
    data_t cpu_q;
    data_t video_q;

    // Write strobes per register
    logic  cpu_we;
    logic  video_we;

    // Status synchronizer
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= status_i;
            // Shift toward the last stage
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign status_sync = sync_q[SYNC_STAGES-1];

    // Place each status input at its bit, upper bits zero
    always_comb begin
        status_byte                          = '0;
        status_byte[REG_STATUS_GRAPHICS_BIT] = status_sync.graphics;
        status_byte[REG_STATUS_CRT_BIT]      = status_sync.crt;
        status_byte[REG_STATUS_KEYBOARD_BIT] = status_sync.keyboard;
    end

    // Write decode
    // Status and unmapped locations have no strobe
    assign cpu_we   = req_i.valid && req_i.write && (req_i.addr == REG_CPU);
    assign video_we = req_i.valid && req_i.write && (req_i.addr == REG_VIDEO);

    // CPU control register
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            // CPU starts held in reset
            cpu_q <= CPU_RESET_VALUE;
        end else if (cpu_we) begin
            // All 8 bits kept so reads match writes
            cpu_q <= req_i.wdata;
        end
    end

    // Video control register
    always_ff @(posedge clock_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            video_q <= VIDEO_RESET_VALUE;
        end else if (video_we) begin
            video_q <= req_i.wdata;
        end
    end

    // Read multiplexer, combinational
    always_comb begin
        case (req_i.addr)
            REG_STATUS: rdata_o = status_byte;
            REG_CPU:    rdata_o = cpu_q;
            REG_VIDEO:  rdata_o = video_q;
            // Unmapped locations read as zero
            default:    rdata_o = '0;
        endcase
    end

    // CPU control lines from their bit positions
    always_comb begin
        cpu_o.ready = cpu_q[REG_CPU_READY_BIT];
        cpu_o.reset = cpu_q[REG_CPU_RESET_BIT];
        cpu_o.nmi   = cpu_q[REG_CPU_NMI_BIT];
    end

    // Video control lines
    always_comb begin
        video_o.col_80_mode = video_q[REG_VIDEO_COL_80_BIT];
        // Two-bit mask field
        video_o.ram_mask    = video_q[REG_VIDEO_RAM_MASK_MSB:REG_VIDEO_RAM_MASK_LSB];
    end

endmodule

// File: rtl/pet_ctl_top.sv
/* PET control register block top */
`timescale 1ns/1ps

module pet_ctl_top
    import pet_regs_pkg::*;
(
    input  logic       clock_i,
    input  logic       reset_n_i,

    // Wishbone pipelined slave port
    input  logic       wb_cycle_i,
    input  logic       wb_strobe_i,
    input  logic       wb_we_i,
    input  logic       wb_sel_i,
    input  reg_addr_t  wb_addr_i,
    input  data_t      wb_data_i,
    output data_t      wb_data_o,
    output logic       wb_ack_o,
    output logic       wb_stall_o,

    // Status inputs, asynchronous
    input  logic       video_graphic_i,
    input  logic       config_crt_i,
    input  logic       config_keyboard_i,

    // CPU control
    output logic       cpu_ready_o,
    output logic       cpu_reset_o,
    output logic       cpu_nmi_o,

    // Video control
    output logic       video_col_80_mode_o,
    output logic [1:0] video_ram_mask_o
);

    // Request from bus slave, read data back
    reg_req_t   req;
    data_t      rdata;

    // Grouped status and control lines
    status_t    status;
    cpu_ctl_t   cpu;
    video_ctl_t video;

    // Gather status pins
    assign status.graphics = video_graphic_i;
    assign status.crt      = config_crt_i;
    assign status.keyboard = config_keyboard_i;

    // Bus front end
    reg_bus_slave reg_bus_slave_i (
        .clock_i    (clock_i),
        .reset_n_i  (reset_n_i),
        .wb_cycle_i (wb_cycle_i),
        .wb_strobe_i(wb_strobe_i),
        .wb_we_i    (wb_we_i),
        .wb_sel_i   (wb_sel_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .wb_data_o  (wb_data_o),
        .wb_ack_o   (wb_ack_o),
        .wb_stall_o (wb_stall_o),
        .req_o      (req),
        .rdata_i    (rdata)
    );

    // Register storage
    register_file register_file_i (
        .clock_i  (clock_i),
        .reset_n_i(reset_n_i),
        .req_i    (req),
        .rdata_o  (rdata),
        .status_i (status),
        .cpu_o    (cpu),
        .video_o  (video)
    );

    // Break control structs onto named ports
    assign cpu_ready_o         = cpu.ready;
    assign cpu_reset_o         = cpu.reset;
    assign cpu_nmi_o           = cpu.nmi;
    assign video_col_80_mode_o = video.col_80_mode;
    assign video_ram_mask_o    = video.ram_mask;

endmodule

// File: tests/pet_ctl_chk.sv
/* Wishbone handshake assertions */
`timescale 1ns/1ps

module pet_ctl_chk
    import pet_regs_pkg::*;
(
    input logic clock_i,
    input logic reset_n_i,
    input logic wb_cycle_i,
    input logic wb_strobe_i,
    input logic wb_ack_i,
    input logic wb_stall_i
);

    // Request taken on this edge
    logic accept;

    assign accept = wb_cycle_i && wb_strobe_i;

    // Single-cycle slave, never stalls
    stall_low: assert property (@(posedge clock_i) disable iff (!reset_n_i) !wb_stall_i)
        else $error("stall raised by the bus slave");

    // Ack follows each accepted strobe
    ack_follows: assert property (@(posedge clock_i) disable iff (!reset_n_i)
        accept |=> wb_ack_i)
        else $error("accepted strobe not acknowledged on the next cycle");

    // No spurious acks
    ack_has_request: assert property (@(posedge clock_i) disable iff (!reset_n_i)
        wb_ack_i |-> $past(accept))
        else $error("ack without a strobe on the previous cycle");

endmodule

// File: tests/pet_ctl_monitor.sv
/* PET control shadow model and checker */
`timescale 1ns/1ps

module pet_ctl_monitor
    import pet_regs_pkg::*;
(
    input  logic       clock_i,
    input  logic       reset_n_i,
    // Bus as seen at the DUT
    input  logic       wb_cycle_i,
    input  logic       wb_strobe_i,
    input  logic       wb_we_i,
    input  logic       wb_sel_i,
    input  reg_addr_t  wb_addr_i,
    input  data_t      wb_wdata_i,
    input  data_t      wb_rdata_i,
    input  logic       wb_ack_i,
    input  logic       wb_stall_i,
    // Status pins and control outputs
    input  status_t    status_i,
    input  cpu_ctl_t   cpu_i,
    input  video_ctl_t video_i,
    // Expected read value from the stimulus file
    input  logic       exp_check_i,
    input  data_t      exp_data_i,
    output int         checks_o,
    output int         errors_o
);

    int      check_count = 0;
    int      error_count = 0;
    data_t   cpu_shadow;
    data_t   video_shadow;
    // Status pins as sampled one and two edges back
    status_t stat_d1;
    status_t stat_d2;
    // Request accepted on the coming edge and acked one cycle later
    logic    pend_valid;
    logic    pend_write;
    logic    pend_file_chk;
    data_t   pend_exp;
    data_t   pend_file_exp;
    logic    check_reset;

    assign checks_o = check_count;
    assign errors_o = error_count;

    task automatic check_value(input string what, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    // Control pins follow the low bits of the shadow registers
    task automatic check_outputs();
        check_value("cpu outputs", {5'b0, cpu_i}, {5'b0, cpu_shadow[2:0]});
        check_value("video outputs", {5'b0, video_i}, {5'b0, video_shadow[2:0]});
    endtask

    function automatic data_t read_model(input reg_addr_t addr);
        case (addr)
            REG_STATUS: return {5'b0, stat_d2.keyboard, stat_d2.crt, stat_d2.graphics};
            REG_CPU:    return cpu_shadow;
            REG_VIDEO:  return video_shadow;
            default:    return '0;
        endcase
    endfunction

    // Negedge sampling where all signals are settled
    always @(negedge clock_i) begin
        if (!reset_n_i) begin
            cpu_shadow   = CPU_RESET_VALUE;
            video_shadow = VIDEO_RESET_VALUE;
            stat_d1      = '0;
            stat_d2      = '0;
            pend_valid   = 1'b0;
            check_reset  = 1'b1;
        end else begin
            if (check_reset) begin
                check_outputs();
                check_reset = 1'b0;
            end
            if (wb_stall_i !== 1'b0) begin
                report_error("stall output went high");
            end
            // Exactly one ack one cycle after each request
            if (wb_ack_i !== pend_valid) begin
                report_error(pend_valid ? "request got no ack on the next cycle"
                                        : "ack without an accepted request");
            end else if (pend_valid && !pend_write) begin
                check_value("read data", wb_rdata_i, pend_exp);
                if (pend_file_chk) begin
                    check_value("read data against stimulus", wb_rdata_i, pend_file_exp);
                end
            end else if (pend_valid) begin
                check_value("data on write ack", wb_rdata_i, '0);
                check_outputs();
            end

            pend_valid    = wb_cycle_i && wb_strobe_i;
            pend_write    = wb_we_i;
            pend_file_chk = exp_check_i;
            pend_file_exp = exp_data_i;
            pend_exp      = read_model(wb_addr_i);
            // Select low or a read-only address leaves the shadow alone
            if (pend_valid && wb_we_i && wb_sel_i) begin
                if (wb_addr_i == REG_CPU) begin
                    cpu_shadow = wb_wdata_i;
                end else if (wb_addr_i == REG_VIDEO) begin
                    video_shadow = wb_wdata_i;
                end
            end
            stat_d2 = stat_d1;
            stat_d1 = status_i;
        end
    end

endmodule

// File: tests/pet_ctl_tb.sv
/* PET control block testbench */
`timescale 1ns/1ps

module pet_ctl_tb
    import pet_regs_pkg::*;
();

    localparam int ACK_TIMEOUT   = 20;
    localparam int RESET_CYCLES  = 4;
    localparam int STATUS_SETTLE = 3;
    // Operation codes of the stimulus file
    localparam int OP_WRITE       = 0;
    localparam int OP_READ        = 1;
    localparam int OP_STATUS      = 2;
    localparam int OP_BURST       = 3;
    localparam int OP_WRITE_NOSEL = 4;

    logic        clock = 1'b0;
    logic        reset_n = 1'b0;
    logic        wb_cycle;
    logic        wb_strobe;
    logic        wb_we;
    logic        wb_sel;
    reg_addr_t   wb_addr;
    data_t       wb_wdata;
    data_t       wb_rdata;
    logic        wb_ack;
    logic        wb_stall;
    logic        video_graphic;
    logic        config_crt;
    logic        config_keyboard;
    logic        cpu_ready;
    logic        cpu_reset;
    logic        cpu_nmi;
    logic        video_col_80_mode;
    logic [1:0]  video_ram_mask;
    // Expected read value handed to the monitor with the request
    logic        exp_check;
    data_t       exp_data;
    int          checks;
    int          mon_errors;
    int          tb_errors = 0;
    int          tests_done = 0;
    // Requests driven and acks seen
    int          issued = 0;
    int          ack_count = 0;
    logic [31:0] rand_state;

    always #5 clock = ~clock;

    // Acks counted where they are stable
    always @(negedge clock) begin
        if (wb_ack) begin
            ack_count++;
        end
    end

    pet_ctl_top pet_ctl_top_i (
        .clock_i            (clock),
        .reset_n_i          (reset_n),
        .wb_cycle_i         (wb_cycle),
        .wb_strobe_i        (wb_strobe),
        .wb_we_i            (wb_we),
        .wb_sel_i           (wb_sel),
        .wb_addr_i          (wb_addr),
        .wb_data_i          (wb_wdata),
        .wb_data_o          (wb_rdata),
        .wb_ack_o           (wb_ack),
        .wb_stall_o         (wb_stall),
        .video_graphic_i    (video_graphic),
        .config_crt_i       (config_crt),
        .config_keyboard_i  (config_keyboard),
        .cpu_ready_o        (cpu_ready),
        .cpu_reset_o        (cpu_reset),
        .cpu_nmi_o          (cpu_nmi),
        .video_col_80_mode_o(video_col_80_mode),
        .video_ram_mask_o   (video_ram_mask)
    );

    pet_ctl_monitor pet_ctl_monitor_i (
        .clock_i    (clock),
        .reset_n_i  (reset_n),
        .wb_cycle_i (wb_cycle),
        .wb_strobe_i(wb_strobe),
        .wb_we_i    (wb_we),
        .wb_sel_i   (wb_sel),
        .wb_addr_i  (wb_addr),
        .wb_wdata_i (wb_wdata),
        .wb_rdata_i (wb_rdata),
        .wb_ack_i   (wb_ack),
        .wb_stall_i (wb_stall),
        .status_i   ({config_keyboard, config_crt, video_graphic}),
        .cpu_i      ({cpu_nmi, cpu_reset, cpu_ready}),
        .video_i    ({video_ram_mask, video_col_80_mode}),
        .exp_check_i(exp_check),
        .exp_data_i (exp_data),
        .checks_o   (checks),
        .errors_o   (mon_errors)
    );

    // Handshake assertions on the bus slave
    bind reg_bus_slave pet_ctl_chk pet_ctl_chk_i (
        .clock_i    (clock_i),
        .reset_n_i  (reset_n_i),
        .wb_cycle_i (wb_cycle_i),
        .wb_strobe_i(wb_strobe_i),
        .wb_ack_i   (wb_ack_o),
        .wb_stall_i (wb_stall_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int error_total();
        return tb_errors + mon_errors;
    endfunction

    // One request for one cycle, returns 1 ns after the accepting edge
    task automatic issue(input logic we, input logic sel, input reg_addr_t addr,
                         input data_t data, input logic chk, input data_t exp);
        wb_cycle  = 1'b1;
        wb_strobe = 1'b1;
        wb_we     = we;
        wb_sel    = sel;
        wb_addr   = addr;
        wb_wdata  = data;
        exp_check = chk;
        exp_data  = exp;
        issued++;
        @(posedge clock);
        #1;
        wb_cycle  = 1'b0;
        wb_strobe = 1'b0;
        wb_we     = 1'b0;
        wb_sel    = 1'b0;
        exp_check = 1'b0;
    endtask

    // Until every strobe has its ack
    task automatic wait_acks();
        int waited;
        waited = 0;
        while (ack_count != issued && waited < ACK_TIMEOUT) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (ack_count != issued) begin
            $display("timeout: %0d requests issued but %0d acks seen", issued, ack_count);
            tb_errors++;
            issued = ack_count;
        end
    endtask

    // Pins change, then the synchronizer settles
    task automatic set_status(input logic [2:0] bits);
        int waited;
        video_graphic   = bits[0];
        config_crt      = bits[1];
        config_keyboard = bits[2];
        waited = 0;
        while (waited < STATUS_SETTLE) begin
            @(posedge clock);
            #1;
            waited++;
        end
    endtask

    // Back-to-back writes, then back-to-back reads of the last values
    task automatic run_burst(input int count);
        data_t last_cpu;
        data_t last_video;
        for (int i = 0; i < count; i++) begin
            rand_state = xorshift32(rand_state);
            last_cpu = rand_state[7:0];
            issue(1'b1, 1'b1, REG_CPU, last_cpu, 1'b0, '0);
            rand_state = xorshift32(rand_state);
            last_video = rand_state[7:0];
            issue(1'b1, 1'b1, REG_VIDEO, last_video, 1'b0, '0);
        end
        issue(1'b0, 1'b1, REG_CPU, '0, 1'b1, last_cpu);
        issue(1'b0, 1'b1, REG_VIDEO, '0, 1'b1, last_video);
        issue(1'b0, 1'b1, REG_CPU, '0, 1'b1, last_cpu);
        wait_acks();
    endtask

    task automatic run_op(input int op, input logic [31:0] addr, input logic [31:0] data,
                          input logic [31:0] exp);
        case (op)
            OP_WRITE: begin
                issue(1'b1, 1'b1, addr[3:0], data[7:0], 1'b0, '0);
                wait_acks();
            end
            OP_READ: begin
                issue(1'b0, 1'b1, addr[3:0], '0, 1'b1, exp[7:0]);
                wait_acks();
            end
            OP_STATUS:      set_status(data[2:0]);
            OP_BURST:       run_burst(int'(data));
            OP_WRITE_NOSEL: begin
                issue(1'b1, 1'b0, addr[3:0], data[7:0], 1'b0, '0);
                wait_acks();
            end
            default: begin
                $display("unknown operation %0d in the stimulus file", op);
                tb_errors++;
            end
        endcase
    endtask

    task automatic finish_test(input int num, input int base);
        $display("test %0d finished, %0d errors", num, error_total() - base);
        tests_done++;
    endtask

    initial begin
        int          fd;
        int          fields;
        int          test_num;
        int          op;
        int          prev_test;
        int          test_base;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_exp;
        string       line;

        wb_cycle        = 1'b0;
        wb_strobe       = 1'b0;
        wb_we           = 1'b0;
        wb_sel          = 1'b0;
        wb_addr         = '0;
        wb_wdata        = '0;
        exp_check       = 1'b0;
        exp_data        = '0;
        video_graphic   = 1'b0;
        config_crt      = 1'b0;
        config_keyboard = 1'b0;
        rand_state      = 32'd13;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset_n = 1'b1;
        @(posedge clock);
        #1;

        prev_test = -1;
        test_base = 0;
        fd = $fopen("tests/pet_ctl_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) == 0) begin
                    line = "";
                end
                // Comment and blank lines give fewer than five fields
                fields = $sscanf(line, "%d %d %h %h %h", test_num, op, f_addr, f_data, f_exp);
                if (fields == 5) begin
                    if (test_num != prev_test) begin
                        if (prev_test >= 0) begin
                            finish_test(prev_test, test_base);
                        end
                        prev_test = test_num;
                        test_base = error_total();
                    end
                    run_op(op, f_addr, f_data, f_exp);
                end
            end
            $fclose(fd);
            if (prev_test >= 0) begin
                finish_test(prev_test, test_base);
            end else begin
                $display("the stimulus file holds no operations");
                tb_errors++;
            end
        end

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, error_total());
        if (error_total() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/pet_ctl_stimulus.txt
# columns: test op addr data expect; test and op decimal, the rest hex
# op 0 write, 1 read, 2 set status pins, 3 burst of data write pairs, 4 write with select low
1 1 1 00 02
1 1 2 00 00
2 0 1 01 00
2 1 1 00 01
2 0 1 06 00
2 1 1 00 06
2 0 1 fd 00
2 1 1 00 fd
3 0 2 01 00
3 1 2 00 01
3 0 2 02 00
3 1 2 00 02
3 0 2 03 00
3 1 2 00 03
3 0 2 04 00
3 1 2 00 04
3 0 2 05 00
3 1 2 00 05
3 0 2 06 00
3 1 2 00 06
3 0 2 07 00
3 1 2 00 07
3 0 2 00 00
3 1 2 00 00
4 2 0 07 00
4 1 0 00 07
4 0 0 ff 00
4 1 0 00 07
4 2 0 05 00
4 1 0 00 05
4 1 3 00 00
4 1 f 00 00
4 0 5 5a 00
4 1 5 00 00
5 0 1 05 00
5 4 1 3a 00
5 1 1 00 05
5 0 2 06 00
5 4 2 01 00
5 1 2 00 06
6 3 0 06 00

// File: vlog.f
rtl/pet_regs_pkg.sv
rtl/reg_bus_slave.sv
rtl/register_file.sv
rtl/pet_ctl_top.sv
tests/pet_ctl_chk.sv
tests/pet_ctl_monitor.sv
tests/pet_ctl_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the PET control block testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module pet_ctl_tb -o pet_ctl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# Keep running after an assertion so the testbench reports the result
output=$(./obj_dir/pet_ctl_sim +verilator+error+limit+1000)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
